// ==== verification/l1d_cache_stim.txt ====
# op (0 read, 1 write, 2 memory check) addr wdata wstrb expected_data expected_hit
# set 0x10 holds tags at 1040, 2040 and 3040; untouched memory reads as ~addr
0 00001040 00000000 0 ffffefbf 0
0 00001040 00000000 0 ffffefbf 1
0 00002040 00000000 0 ffffdfbf 0
0 00001040 00000000 0 ffffefbf 1
0 00002040 00000000 0 ffffdfbf 1
0 00003040 00000000 0 ffffcfbf 0
0 00002040 00000000 0 ffffdfbf 1
0 00001040 00000000 0 ffffefbf 0
1 00001040 12345678 3 ffff5678 1
0 00001040 00000000 0 ffff5678 1
0 00002040 00000000 0 ffffdfbf 1
0 00003040 00000000 0 ffffcfbf 0
2 00001040 00000000 0 ffff5678 0
0 00001040 00000000 0 ffff5678 0
1 00002040 a5a5a5a5 c a5a5dfbf 0
0 00002040 00000000 0 a5a5dfbf 1
0 00003040 00000000 0 ffffcfbf 0
0 00001040 00000000 0 ffff5678 0
2 00002040 00000000 0 a5a5dfbf 0
0 00002040 00000000 0 a5a5dfbf 0
1 00000100 deadbeef f deadbeef 0
0 00000100 00000000 0 deadbeef 1
0 00000104 00000000 0 fffffefb 0
0 00000104 00000000 0 fffffefb 1
1 00001040 00000000 8 00ff5678 1
0 00001040 00000000 0 00ff5678 1

// ==== filelist.f ====
design/l1d_pkg.sv
design/cache_way.sv
design/cache_req_ctrl.sv
design/way_select.sv
design/l1d_cache.sv
verification/l1d_cache_chk.sv
verification/l1d_cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= l1d_cache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/l1d_cache_tb.sv ====
// testbench with clock, reset, memory model, stim file requests and response checks.
`timescale 1ns/100ps

module l1d_cache_tb;

    localparam int    INDEX_W      = 8;
    localparam int    RESET_CYCLES = 10;
    localparam int    TIMEOUT      = 200;
    localparam int    HIT_LATENCY  = 2;  // accept edge to response edge.
    localparam string STIM_FILE    = "verification/l1d_cache_stim.txt";

    logic                       clk = 1'b0;
    logic                       rst_i;
    logic                       req_i;
    l1d_pkg::req_op_e           req_op_i;
    logic [l1d_pkg::ADDR_W-1:0] req_addr_i;
    logic [l1d_pkg::DATA_W-1:0] req_wdata_i;
    logic [3:0]                 req_wstrb_i;
    logic                       busy_o;
    logic                       rsp_valid_o;
    logic                       rsp_hit_o;
    logic [l1d_pkg::DATA_W-1:0] rsp_rdata_o;
    logic                       mem_valid_o;
    logic                       mem_we_o;
    logic [l1d_pkg::ADDR_W-1:0] mem_addr_o;
    logic [l1d_pkg::DATA_W-1:0] mem_wdata_o;
    logic                       mem_ready_i;
    logic [l1d_pkg::DATA_W-1:0] mem_rdata_i;

    logic [31:0] lcg_state;
    logic [31:0] mem_words [logic [31:0]];  // written words by address.

    l1d_cache #(.INDEX_W(INDEX_W)) i_l1d_cache (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_wstrb_i (req_wstrb_i),
        .busy_o      (busy_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_hit_o   (rsp_hit_o),
        .rsp_rdata_o (rsp_rdata_o),
        .mem_valid_o (mem_valid_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i)
    );

    bind l1d_cache l1d_cache_chk i_chk (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .rsp_valid_o (rsp_valid_o),
        .mem_valid_o (mem_valid_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i),
        .state_i     (i_ctrl.state_q)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (mem_words.exists(addr)) return mem_words[addr];
        return ~addr;  // untouched words hold the inverted address.
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_quiet(input string phase);
        assert (busy_o === 1'b0 && rsp_valid_o === 1'b0 && mem_valid_o === 1'b0)
        else abort_run($sformatf("FAILED at %0d ns: strobe %s, busy %b rsp %b mem %b",
                                 $time, phase, busy_o, rsp_valid_o, mem_valid_o));
    endtask

    // ************************************************************
    // request side.
    // ************************************************************
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy_o !== 1'b0) begin
            if (cycles >= TIMEOUT) begin
                abort_run($sformatf("timeout: busy_o stayed high for %0d cycles", TIMEOUT));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic send_request(input l1d_pkg::req_op_e op, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] wstrb);
        wait_idle();
        req_i       = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_wstrb_i = wstrb;
        @(negedge clk);  // accept edge has passed.
        req_i = 1'b0;
        assert (busy_o === 1'b1)
        else abort_run($sformatf("FAILED at %0d ns: busy %b after the accept edge, expected 1",
                                 $time, busy_o));
    endtask

    // counts rising edges after the accept edge.
    task automatic wait_response(output int cycles);
        cycles = 0;
        while (rsp_valid_o !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                abort_run($sformatf("timeout: no response within %0d cycles", TIMEOUT));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_response(input int line_no, input logic [31:0] exp_data,
                                  input logic exp_hit, input int cycles);
        assert (rsp_rdata_o === exp_data)
        else abort_run($sformatf("FAILED at %0d ns: line %0d data %h, expected %h",
                                 $time, line_no, rsp_rdata_o, exp_data));
        assert (rsp_hit_o === exp_hit)
        else abort_run($sformatf("FAILED at %0d ns: line %0d hit %b, expected %b",
                                 $time, line_no, rsp_hit_o, exp_hit));
        assert (busy_o === 1'b0)
        else abort_run($sformatf("FAILED at %0d ns: line %0d busy %b with the response",
                                 $time, line_no, busy_o));
        if (exp_hit) begin
            assert (cycles == HIT_LATENCY)
            else abort_run($sformatf("FAILED at %0d ns: line %0d hit latency %0d, expected %0d",
                                     $time, line_no, cycles, HIT_LATENCY));
        end
    endtask

    // ************************************************************
    // memory model with a response delay of 0 to 3 cycles.
    // ************************************************************
    initial begin
        int unsigned delay;
        logic        pending;
        lcg_state   = 32'h88a43687;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        pending     = 1'b0;
        delay       = 0;
        forever begin
            @(negedge clk);
            mem_ready_i = 1'b0;
            if (rst_i || mem_valid_o !== 1'b1) begin
                pending = 1'b0;
            end else begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = lcg_next() >> 30;
                end
                if (delay == 0) begin
                    mem_ready_i = 1'b1;
                    pending     = 1'b0;
                    if (mem_we_o) mem_words[mem_addr_o] = mem_wdata_o;
                    else mem_rdata_i = mem_read(mem_addr_o);
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        int          fd;
        int          line_no;
        int          n_fields;
        int          op_code;
        int          exp_hit;
        int          cycles;
        string       line;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic [3:0]  wstrb;
        rst_i       = 1'b1;
        req_i       = 1'b0;
        req_op_i    = l1d_pkg::OP_READ;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_wstrb_i = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        rst_i = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_quiet("after reset");
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) abort_run({"cannot open the stimulus file ", STIM_FILE});
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n_fields = $sscanf(line, "%d %h %h %h %h %d",
                               op_code, addr, wdata, wstrb, exp_data, exp_hit);
            if (n_fields != 6) abort_run($sformatf("stimulus line %0d is malformed", line_no));
            if (op_code == 2) begin
                assert (mem_read(addr) === exp_data)
                else abort_run($sformatf("FAILED at %0d ns: line %0d memory %h, expected %h",
                                         $time, line_no, mem_read(addr), exp_data));
            end else begin
                send_request(op_code == 1 ? l1d_pkg::OP_WRITE : l1d_pkg::OP_READ,
                             addr, wdata, wstrb);
                wait_response(cycles);
                check_response(line_no, exp_data, exp_hit != 0, cycles);
            end
        end
        $fclose(fd);
        $display("No errors");
        $finish;
    end

endmodule

// ==== verification/l1d_cache_chk.sv ====
// bound assertions on the request and memory handshakes and the controller FSM.
`timescale 1ns/100ps

module l1d_cache_chk (
    input logic                       clk,
    input logic                       rst_i,
    input logic                       req_i,
    input logic                       busy_o,
    input logic                       rsp_valid_o,
    input logic                       mem_valid_o,
    input logic                       mem_we_o,
    input logic [l1d_pkg::ADDR_W-1:0] mem_addr_o,
    input logic [l1d_pkg::DATA_W-1:0] mem_wdata_o,
    input logic                       mem_ready_i,
    input l1d_pkg::ctrl_state_e       state_i
);

    req_free: assert property (@(posedge clk) disable iff (rst_i) !(req_i && busy_o))
        else $error("request strobe while the cache is busy");

    // memory request is held until the ready edge.
    mem_hold: assert property (@(posedge clk) disable iff (rst_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_we_o)
            && $stable(mem_addr_o) && $stable(mem_wdata_o))
        else $error("memory request changed before mem_ready_i");

    rsp_single: assert property (@(posedge clk) disable iff (rst_i) rsp_valid_o |=> !rsp_valid_o)
        else $error("response strobe longer than one cycle");

    // a finished refill makes the second lookup hit.
    refill_hit: assert property (@(posedge clk) disable iff (rst_i)
        (state_i == l1d_pkg::S_REFILL) && mem_ready_i |-> ##3 rsp_valid_o)
        else $error("no hit response three cycles after the refill");

endmodule

// ==== design/l1d_cache.sv ====
// top level with the request controller, the generated cache ways and the way selector.
`timescale 1ns/100ps

module l1d_cache #(
    parameter int INDEX_W = 8,
    localparam int TAG_W  = l1d_pkg::ADDR_W - INDEX_W - l1d_pkg::OFFSET_W,
    localparam int WAY_W  = $clog2(l1d_pkg::NUM_WAYS),
    localparam int STRB_W = l1d_pkg::DATA_W / 8
) (
    input  logic                       clk,
    input  logic                       rst_i,

    input  logic                       req_i,
    input  l1d_pkg::req_op_e           req_op_i,
    input  logic [l1d_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [l1d_pkg::DATA_W-1:0] req_wdata_i,
    input  logic [STRB_W-1:0]          req_wstrb_i,
    output logic                       busy_o,
    output logic                       rsp_valid_o,
    output logic                       rsp_hit_o,
    output logic [l1d_pkg::DATA_W-1:0] rsp_rdata_o,

    output logic                       mem_valid_o,
    output logic                       mem_we_o,
    output logic [l1d_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [l1d_pkg::DATA_W-1:0] mem_wdata_o,
    input  logic                       mem_ready_i,
    input  logic [l1d_pkg::DATA_W-1:0] mem_rdata_i
);

    logic                                   lookup;
    logic [INDEX_W-1:0]                     index;
    logic [TAG_W-1:0]                       tag;
    logic [l1d_pkg::NUM_WAYS-1:0]           way_wr_en;
    logic [l1d_pkg::DATA_W-1:0]             wr_data;
    logic [STRB_W-1:0]                      wr_wstrb;
    logic [TAG_W-1:0]                       wr_tag;
    logic                                   wr_dirty;
    logic                                   lru_touch;

    logic [l1d_pkg::NUM_WAYS-1:0]           way_hit;
    logic [l1d_pkg::NUM_WAYS*l1d_pkg::DATA_W-1:0] way_rdata;
    logic [l1d_pkg::NUM_WAYS-1:0]           way_dirty;
    logic [l1d_pkg::NUM_WAYS*TAG_W-1:0]     way_tag;

    logic                                   any_hit;
    logic [WAY_W-1:0]                       hit_way;
    logic [WAY_W-1:0]                       victim_way;
    logic                                   victim_dirty;
    logic [TAG_W-1:0]                       victim_tag;
    logic [l1d_pkg::DATA_W-1:0]             sel_rdata;

    cache_req_ctrl #(.INDEX_W(INDEX_W)) i_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .req_op_i       (req_op_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_wstrb_i    (req_wstrb_i),
        .busy_o         (busy_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_hit_o      (rsp_hit_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .mem_valid_o    (mem_valid_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ready_i    (mem_ready_i),
        .mem_rdata_i    (mem_rdata_i),
        .lookup_o       (lookup),
        .index_o        (index),
        .tag_o          (tag),
        .way_wr_en_o    (way_wr_en),
        .wr_data_o      (wr_data),
        .wr_wstrb_o     (wr_wstrb),
        .wr_tag_o       (wr_tag),
        .wr_dirty_o     (wr_dirty),
        .lru_touch_o    (lru_touch),
        .any_hit_i      (any_hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .sel_rdata_i    (sel_rdata)
    );

    // ************************************************************
    // cache ways.
    // ************************************************************
    for (genvar w = 0; w < l1d_pkg::NUM_WAYS; w++) begin : g_way
        cache_way #(.INDEX_W(INDEX_W)) i_way (
            .clk        (clk),
            .rst_i      (rst_i),
            .lookup_i   (lookup),
            .index_i    (index),
            .tag_i      (tag),
            .wr_en_i    (way_wr_en[w]),
            .wr_data_i  (wr_data),
            .wr_wstrb_i (wr_wstrb),
            .wr_tag_i   (wr_tag),
            .wr_dirty_i (wr_dirty),
            .hit_o      (way_hit[w]),
            .rdata_o    (way_rdata[w*l1d_pkg::DATA_W +: l1d_pkg::DATA_W]),
            .dirty_o    (way_dirty[w]),
            .tag_o      (way_tag[w*TAG_W +: TAG_W])
        );
    end

    way_select #(.INDEX_W(INDEX_W)) i_sel (
        .clk            (clk),
        .rst_i          (rst_i),
        .index_i        (index),
        .way_hit_i      (way_hit),
        .way_rdata_i    (way_rdata),
        .way_dirty_i    (way_dirty),
        .way_tag_i      (way_tag),
        .lru_touch_i    (lru_touch),
        .touch_way_i    (hit_way),  // only hits touch the lru.
        .any_hit_o      (any_hit),
        .hit_way_o      (hit_way),
        .sel_rdata_o    (sel_rdata),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

endmodule

// ==== design/way_select.sv ====
// hit merge, read-data mux, per-set LRU bits and victim choice.
`timescale 1ns/100ps

module way_select #(
    parameter int INDEX_W = 8,
    localparam int TAG_W  = l1d_pkg::ADDR_W - INDEX_W - l1d_pkg::OFFSET_W,
    localparam int WAY_W  = $clog2(l1d_pkg::NUM_WAYS)
) (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic [INDEX_W-1:0]                      index_i,

    input  logic [l1d_pkg::NUM_WAYS-1:0]            way_hit_i,
    input  logic [l1d_pkg::NUM_WAYS*l1d_pkg::DATA_W-1:0] way_rdata_i,
    input  logic [l1d_pkg::NUM_WAYS-1:0]            way_dirty_i,
    input  logic [l1d_pkg::NUM_WAYS*TAG_W-1:0]      way_tag_i,

    input  logic                                    lru_touch_i,
    input  logic [WAY_W-1:0]                        touch_way_i,

    output logic                                    any_hit_o,
    output logic [WAY_W-1:0]                        hit_way_o,
    output logic [l1d_pkg::DATA_W-1:0]              sel_rdata_o,
    output logic [WAY_W-1:0]                        victim_way_o,
    output logic                                    victim_dirty_o,
    output logic [TAG_W-1:0]                        victim_tag_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0] lru_q;  // least recently used way of each set.
    logic [WAY_W-1:0] sel_way;

    // ************************************************************
    // hit merge and data mux.
    // ************************************************************
    always_comb begin
        hit_way_o = '0;
        for (int w = l1d_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (way_hit_i[w]) hit_way_o = WAY_W'(w);
        end
    end

    assign any_hit_o   = |way_hit_i;
    assign sel_way     = any_hit_o ? hit_way_o : victim_way_o;  // victim word on a miss.
    assign sel_rdata_o = way_rdata_i[sel_way*l1d_pkg::DATA_W +: l1d_pkg::DATA_W];

    // victim and its state.
    assign victim_way_o   = lru_q[index_i];
    assign victim_dirty_o = way_dirty_i[victim_way_o];
    assign victim_tag_o   = way_tag_i[victim_way_o*TAG_W +: TAG_W];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            lru_q <= '0;
        end else if (lru_touch_i) begin
            lru_q[index_i] <= ~touch_way_i;  // the other way becomes lru.
        end
    end

endmodule

// ==== design/cache_req_ctrl.sv ====
// request FSM that sequences lookup, write-back, refill and response.
`timescale 1ns/100ps

module cache_req_ctrl #(
    parameter int INDEX_W = 8,
    localparam int TAG_W  = l1d_pkg::ADDR_W - INDEX_W - l1d_pkg::OFFSET_W,
    localparam int WAY_W  = $clog2(l1d_pkg::NUM_WAYS),
    localparam int STRB_W = l1d_pkg::DATA_W / 8
) (
    input  logic                        clk,
    input  logic                        rst_i,

    input  logic                        req_i,
    input  l1d_pkg::req_op_e            req_op_i,
    input  logic [l1d_pkg::ADDR_W-1:0]  req_addr_i,
    input  logic [l1d_pkg::DATA_W-1:0]  req_wdata_i,
    input  logic [STRB_W-1:0]           req_wstrb_i,
    output logic                        busy_o,
    output logic                        rsp_valid_o,
    output logic                        rsp_hit_o,
    output logic [l1d_pkg::DATA_W-1:0]  rsp_rdata_o,

    output logic                        mem_valid_o,
    output logic                        mem_we_o,
    output logic [l1d_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic [l1d_pkg::DATA_W-1:0]  mem_wdata_o,
    input  logic                        mem_ready_i,
    input  logic [l1d_pkg::DATA_W-1:0]  mem_rdata_i,

    output logic                        lookup_o,
    output logic [INDEX_W-1:0]          index_o,
    output logic [TAG_W-1:0]            tag_o,
    output logic [l1d_pkg::NUM_WAYS-1:0] way_wr_en_o,
    output logic [l1d_pkg::DATA_W-1:0]  wr_data_o,
    output logic [STRB_W-1:0]           wr_wstrb_o,
    output logic [TAG_W-1:0]            wr_tag_o,
    output logic                        wr_dirty_o,
    output logic                        lru_touch_o,

    input  logic                        any_hit_i,
    input  logic [WAY_W-1:0]            hit_way_i,
    input  logic [WAY_W-1:0]            victim_way_i,
    input  logic                        victim_dirty_i,
    input  logic [TAG_W-1:0]            victim_tag_i,
    input  logic [l1d_pkg::DATA_W-1:0]  sel_rdata_i
);

    l1d_pkg::ctrl_state_e       state_q;
    l1d_pkg::req_op_e           op_q;
    logic [l1d_pkg::ADDR_W-1:0] addr_q;
    logic [l1d_pkg::DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0]          wstrb_q;
    logic                       cmp_q;   // way outputs valid in the second lookup cycle.
    logic                       miss_q;  // first lookup of this request missed.
    logic [WAY_W-1:0]           victim_q;
    logic [TAG_W-1:0]           victim_tag_q;
    logic [l1d_pkg::DATA_W-1:0] wb_data_q;
    logic [l1d_pkg::DATA_W-1:0] rsp_data_q;
    logic [l1d_pkg::DATA_W-1:0] merged;
    logic                       accept;
    logic                       decide;

    assign busy_o = (state_q != l1d_pkg::S_IDLE) && (state_q != l1d_pkg::S_RESPOND);
    assign accept = req_i && !busy_o;
    assign decide = (state_q == l1d_pkg::S_LOOKUP) && cmp_q;

    // ************************************************************
    // state machine.
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= l1d_pkg::S_IDLE;
            cmp_q   <= 1'b0;
            miss_q  <= 1'b0;
        end else begin
            cmp_q <= (state_q == l1d_pkg::S_LOOKUP) && !cmp_q;
            case (state_q)
                l1d_pkg::S_IDLE, l1d_pkg::S_RESPOND: begin
                    state_q <= accept ? l1d_pkg::S_LOOKUP : l1d_pkg::S_IDLE;
                    if (accept) miss_q <= 1'b0;
                end
                l1d_pkg::S_LOOKUP: begin
                    if (cmp_q && any_hit_i) begin
                        state_q <= l1d_pkg::S_RESPOND;
                    end else if (cmp_q) begin
                        miss_q  <= 1'b1;
                        state_q <= victim_dirty_i ? l1d_pkg::S_WRITEBACK : l1d_pkg::S_REFILL;
                    end
                end
                l1d_pkg::S_WRITEBACK: if (mem_ready_i) state_q <= l1d_pkg::S_REFILL;
                l1d_pkg::S_REFILL:    if (mem_ready_i) state_q <= l1d_pkg::S_LOOKUP;
                default:              state_q <= l1d_pkg::S_IDLE;
            endcase
        end
    end

    // request, victim and response payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            wstrb_q <= req_wstrb_i;
        end
        if (decide) begin
            victim_q     <= victim_way_i;
            victim_tag_q <= victim_tag_i;
            wb_data_q    <= sel_rdata_i;  // selector shows the victim word on a miss.
            rsp_data_q   <= (op_q == l1d_pkg::OP_WRITE) ? merged : sel_rdata_i;
        end
    end

    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            merged[b*8 +: 8] = wstrb_q[b] ? wdata_q[b*8 +: 8] : sel_rdata_i[b*8 +: 8];
        end
    end

    // ************************************************************
    // refill into the victim way and write hits into the hit way.
    // ************************************************************
    always_comb begin
        way_wr_en_o = '0;
        wr_data_o   = wdata_q;
        wr_wstrb_o  = wstrb_q;
        wr_dirty_o  = 1'b1;
        if (state_q == l1d_pkg::S_REFILL) begin
            way_wr_en_o[victim_q] = mem_ready_i;
            wr_data_o             = mem_rdata_i;
            wr_wstrb_o            = '1;
            wr_dirty_o            = 1'b0;  // fresh copy of memory.
        end else if (decide && any_hit_i && (op_q == l1d_pkg::OP_WRITE)) begin
            way_wr_en_o[hit_way_i] = 1'b1;
        end
    end

    assign lookup_o    = (state_q == l1d_pkg::S_LOOKUP) && !cmp_q;
    assign index_o     = addr_q[l1d_pkg::OFFSET_W +: INDEX_W];
    assign tag_o       = addr_q[l1d_pkg::ADDR_W-1 -: TAG_W];
    assign wr_tag_o    = tag_o;
    assign lru_touch_o = decide && any_hit_i;

    assign mem_valid_o = (state_q == l1d_pkg::S_WRITEBACK) || (state_q == l1d_pkg::S_REFILL);
    assign mem_we_o    = (state_q == l1d_pkg::S_WRITEBACK);
    assign mem_addr_o  = {mem_we_o ? victim_tag_q : tag_o, index_o, {l1d_pkg::OFFSET_W{1'b0}}};
    assign mem_wdata_o = wb_data_q;

    assign rsp_valid_o = (state_q == l1d_pkg::S_RESPOND);
    assign rsp_hit_o   = !miss_q;
    assign rsp_rdata_o = rsp_data_q;

endmodule

// ==== design/cache_way.sv ====
// one cache way with tag and data arrays, valid and dirty flags and the tag compare.
`timescale 1ns/100ps

module cache_way #(
    parameter int INDEX_W = 8,
    localparam int TAG_W  = l1d_pkg::ADDR_W - INDEX_W - l1d_pkg::OFFSET_W,
    localparam int STRB_W = l1d_pkg::DATA_W / 8
) (
    input  logic                      clk,
    input  logic                      rst_i,

    input  logic                      lookup_i,
    input  logic [INDEX_W-1:0]        index_i,
    input  logic [TAG_W-1:0]          tag_i,

    input  logic                      wr_en_i,
    input  logic [l1d_pkg::DATA_W-1:0] wr_data_i,
    input  logic [STRB_W-1:0]         wr_wstrb_i,
    input  logic [TAG_W-1:0]          wr_tag_i,
    input  logic                      wr_dirty_i,

    output logic                      hit_o,
    output logic [l1d_pkg::DATA_W-1:0] rdata_o,
    output logic                      dirty_o,
    output logic [TAG_W-1:0]          tag_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]           tag_mem  [SETS];
    logic [l1d_pkg::DATA_W-1:0] data_mem [SETS];
    logic [SETS-1:0]            valid_q;
    logic [SETS-1:0]            dirty_q;

    logic [TAG_W-1:0]           rd_tag_q;
    logic [l1d_pkg::DATA_W-1:0] rd_data_q;
    logic [TAG_W-1:0]           req_tag_q;  // tag of the request being compared.
    logic                       rd_valid_q;
    logic                       rd_dirty_q;

    // ************************************************************
    // per-set valid and dirty flags.
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else begin
            if (lookup_i) begin
                rd_valid_q <= valid_q[index_i];
                rd_dirty_q <= dirty_q[index_i];
            end
            if (wr_en_i) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= wr_dirty_i;
            end
        end
    end

    // arrays and read registers.
    always_ff @(posedge clk) begin
        if (lookup_i) begin
            rd_tag_q  <= tag_mem[index_i];
            rd_data_q <= data_mem[index_i];
            req_tag_q <= tag_i;
        end
        if (wr_en_i) begin
            tag_mem[index_i] <= wr_tag_i;
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_wstrb_i[b]) begin
                    data_mem[index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    assign hit_o   = rd_valid_q && (rd_tag_q == req_tag_q);
    assign rdata_o = rd_data_q;
    assign dirty_o = rd_valid_q && rd_dirty_q;  // an invalid line never needs write-back.
    assign tag_o   = rd_tag_q;

endmodule

// ==== design/l1d_pkg.sv ====
// cache geometry constants, controller state enum and request opcode enum.
package l1d_pkg;

    // ************************************************************
    // geometry.
    // ************************************************************
    localparam int NUM_WAYS = 2;  // one lru bit per set covers two ways.
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int OFFSET_W = 2;  // byte offset inside the word.

    // ************************************************************
    // controller states and request opcodes.
    // ************************************************************
    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,     // array read and then tag compare.
        S_WRITEBACK,  // dirty victim goes out to memory.
        S_REFILL,     // missing word comes in from memory.
        S_RESPOND
    } ctrl_state_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } req_op_e;

endpackage
